/* flist.f */
source/core_pkg.sv
source/mem_if.sv
source/arith_if.sv
source/memory.sv
source/pulse_unit.sv
source/arith_unit.sv
source/core_top.sv
verification/core_tb.sv

/* source/arith_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface arith_if import core_pkg::*; ();

    word_t           operand;   // memory data passed on by the pulse unit
    logic            load_a;
    logic            load_b;
    logic            operate;
    logic [OP_W-1:0] op;
    word_t           reg_c;

    modport ctrl (
        output operand, load_a, load_b, operate, op,
        input  reg_c
    );

    // arithmetic side
    modport arith (
        input  operand, load_a, load_b, operate, op,
        output reg_c
    );

endinterface

`default_nettype wire

/* source/arith_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module arith_unit import core_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   pnl_do_arr_c,
    input  word_t  pnl_arr_reg_c_value,
    arith_if.arith alu
);

    word_t            reg_a;
    word_t            reg_b;
    word_t            reg_c;
    word_t            result;
    logic             b_sign;       // B sign after subtract inversion
    logic             a_larger;
    logic [MAG_W-1:0] mag_sum;

    assign b_sign   = (alu.op == OP_SUB) ? ~reg_b.num.sign : reg_b.num.sign;
    assign a_larger = (reg_a.num.mag >= reg_b.num.mag);
    assign mag_sum  = reg_a.num.mag + reg_b.num.mag;   // wraps mod 2^30

    always_comb begin
        case (alu.op)
            OP_ADD, OP_SUB: begin
                if (reg_a.num.sign == b_sign) begin
                    result.num.sign = reg_a.num.sign;
                    result.num.mag  = mag_sum;
                end else if (a_larger) begin
                    result.num.sign = reg_a.num.sign;
                    result.num.mag  = reg_a.num.mag - reg_b.num.mag;
                end else begin
                    result.num.sign = b_sign;
                    result.num.mag  = reg_b.num.mag - reg_a.num.mag;
                end
            end

            OP_AND: begin
                result.num.sign = reg_a.num.sign & reg_b.num.sign;
                result.num.mag  = reg_a.num.mag & reg_b.num.mag;
            end

            default: begin
                result = reg_c;
            end
        endcase

        // no negative zero
        if (result.num.mag == '0) begin
            result.num.sign = 1'b0;
        end
    end

    // operand registers
    always_ff @(posedge clk) begin
        if (alu.load_a) begin
            reg_a <= alu.operand;
        end
        if (alu.load_b) begin
            reg_b <= alu.operand;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_c <= '0;
        end else if (pnl_do_arr_c) begin
            reg_c <= pnl_arr_reg_c_value;   // panel wins over operate
        end else if (alu.operate) begin
            reg_c <= result;
        end
    end

    assign alu.reg_c = reg_c;

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    // machine word is sign plus 30-bit magnitude
    localparam int WORD_W    = 31;
    localparam int MAG_W     = 30;
    localparam int ADDR_W    = 12;
    localparam int OP_W      = 6;
    localparam int STATE_W   = 3;
    localparam int MEM_DEPTH = 4096;

    // order codes, anything else is a no-op
    localparam logic [OP_W-1:0] OP_ADD   = 6'o01;
    localparam logic [OP_W-1:0] OP_SUB   = 6'o02;
    localparam logic [OP_W-1:0] OP_AND   = 6'o05;
    localparam logic [OP_W-1:0] OP_STORE = 6'o11;
    localparam logic [OP_W-1:0] OP_JUMP  = 6'o14;
    localparam logic [OP_W-1:0] OP_STOP  = 6'o17;

    // pulse unit sequencer states
    localparam logic [STATE_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [STATE_W-1:0] ST_FETCH   = 3'd1;
    localparam logic [STATE_W-1:0] ST_DECODE  = 3'd2;
    localparam logic [STATE_W-1:0] ST_READ_A  = 3'd3;
    localparam logic [STATE_W-1:0] ST_READ_B  = 3'd4;
    localparam logic [STATE_W-1:0] ST_LOAD_B  = 3'd5;
    localparam logic [STATE_W-1:0] ST_EXECUTE = 3'd6;
    localparam logic [STATE_W-1:0] ST_STORE   = 3'd7;

    typedef struct packed {
        logic             sign;     // 1 = negative
        logic [MAG_W-1:0] mag;
    } number_t;

    typedef struct packed {
        logic              spare;   // top bit, not decoded
        logic [OP_W-1:0]   op;
        logic [ADDR_W-1:0] addr1;
        logic [ADDR_W-1:0] addr2;
    } order_t;

    // same memory word, read as data or as an order
    typedef union packed {
        number_t num;
        order_t  order;
    } word_t;

endpackage

`default_nettype wire

/* source/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    input  logic               pnl_start_pulse,      // pulse
    input  logic               pnl_clear_pu,         // pulse
    input  logic               pnl_automatic,        // level

    input  logic               pnl_do_arr_c,         // pulse
    input  logic [WORD_W-1:0]  pnl_arr_reg_c_value,

    input  logic               pnl_do_arr_strt,      // pulse
    input  logic [ADDR_W-1:0]  pnl_arr_strt_value,

    input  logic               pnl_do_arr_sel,       // pulse
    input  logic [ADDR_W-1:0]  pnl_arr_sel_value,

    input  logic               pnl_do_store,         // pulse, C to memory at select

    output logic [OP_W-1:0]    pnl_op_code,
    output logic [ADDR_W-1:0]  pnl_strt_value,
    output logic [ADDR_W-1:0]  pnl_sel_value,
    output logic [WORD_W-1:0]  pnl_reg_c_value,
    output logic [STATE_W-1:0] pnl_pu_state
);

    mem_if   mem_bus ();
    arith_if alu_bus ();

    // each arrange value goes to its own register
    pulse_unit u_pulse_unit (
        .clk                ( clk                ),
        .reset              ( reset              ),
        .pnl_start_pulse    ( pnl_start_pulse    ),
        .pnl_clear_pu       ( pnl_clear_pu       ),
        .pnl_automatic      ( pnl_automatic      ),
        .pnl_do_arr_strt    ( pnl_do_arr_strt    ),
        .pnl_arr_strt_value ( pnl_arr_strt_value ),
        .pnl_do_arr_sel     ( pnl_do_arr_sel     ),
        .pnl_arr_sel_value  ( pnl_arr_sel_value  ),
        .pnl_do_store       ( pnl_do_store       ),
        .mem                ( mem_bus.ctrl       ),
        .alu                ( alu_bus.ctrl       ),
        .op_code            ( pnl_op_code        ),
        .strt_value         ( pnl_strt_value     ),
        .sel_value          ( pnl_sel_value      ),
        .state              ( pnl_pu_state       )
    );

    memory u_memory (
        .clk ( clk         ),
        .mem ( mem_bus.mem )
    );

    arith_unit u_arith_unit (
        .clk                 ( clk                 ),
        .reset               ( reset               ),
        .pnl_do_arr_c        ( pnl_do_arr_c        ),
        .pnl_arr_reg_c_value ( pnl_arr_reg_c_value ),
        .alu                 ( alu_bus.arith       )
    );

    assign pnl_reg_c_value = alu_bus.reg_c;

endmodule

`default_nettype wire

/* source/mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_if import core_pkg::*; ();

    logic [ADDR_W-1:0] addr;        // select register
    logic              read;
    logic              write;
    word_t             write_data;
    word_t             read_data;   // valid the cycle after read

    modport ctrl (
        output addr, read, write, write_data,
        input  read_data
    );

    modport mem (
        input  addr, read, write, write_data,
        output read_data
    );

endinterface

`default_nettype wire

/* source/memory.sv */
`timescale 1ns/1ps
`default_nettype none

module memory import core_pkg::*; (
    input  logic clk,
    mem_if.mem   mem
);

    // contents undefined until written
    word_t store [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.write) begin
            store[mem.addr] <= mem.write_data;
        end
    end

    // registered read, holds until the next read strobe
    always_ff @(posedge clk) begin
        if (mem.read) begin
            mem.read_data <= store[mem.addr];
        end
    end

endmodule

`default_nettype wire

/* source/pulse_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_unit import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    input  logic               pnl_start_pulse,
    input  logic               pnl_clear_pu,
    input  logic               pnl_automatic,

    input  logic               pnl_do_arr_strt,
    input  logic [ADDR_W-1:0]  pnl_arr_strt_value,
    input  logic               pnl_do_arr_sel,
    input  logic [ADDR_W-1:0]  pnl_arr_sel_value,

    input  logic               pnl_do_store,

    mem_if.ctrl                mem,
    arith_if.ctrl              alu,

    output logic [OP_W-1:0]    op_code,
    output logic [ADDR_W-1:0]  strt_value,
    output logic [ADDR_W-1:0]  sel_value,
    output logic [STATE_W-1:0] state
);

    logic [ADDR_W-1:0] strt;        // program counter
    logic [ADDR_W-1:0] sel;         // memory address
    word_t             ir;
    word_t             fetched;
    logic              arith_order;
    logic [ADDR_W-1:0] next_strt;

    // order straight from memory, valid in ST_DECODE
    assign fetched     = mem.read_data;
    assign arith_order = (fetched.order.op == OP_ADD) ||
                         (fetched.order.op == OP_SUB) ||
                         (fetched.order.op == OP_AND);

    // jump replaces the increment
    assign next_strt = (fetched.order.op == OP_JUMP) ? fetched.order.addr2
                                                     : strt + ADDR_W'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            strt  <= '0;
            sel   <= '0;
            ir    <= '0;
        end else if (pnl_clear_pu) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // panel arranges only while stopped
                    if (pnl_do_arr_strt) begin
                        strt <= pnl_arr_strt_value;
                    end
                    if (pnl_do_arr_sel) begin
                        sel <= pnl_arr_sel_value;
                    end
                    if (pnl_start_pulse) begin
                        sel   <= strt;
                        state <= ST_FETCH;
                    end
                end

                ST_FETCH: begin
                    state <= ST_DECODE;
                end

                ST_DECODE: begin
                    ir   <= fetched;
                    strt <= next_strt;
                    if (arith_order) begin
                        sel   <= fetched.order.addr1;
                        state <= ST_READ_A;
                    end else if (fetched.order.op == OP_STORE) begin
                        sel   <= fetched.order.addr2;
                        state <= ST_STORE;
                    end else if (fetched.order.op == OP_STOP) begin
                        state <= ST_IDLE;
                    end else if (pnl_automatic) begin
                        sel   <= next_strt;     // jump target or next order
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_IDLE;
                    end
                end

                ST_READ_A: begin
                    sel   <= ir.order.addr2;
                    state <= ST_READ_B;
                end

                ST_READ_B: begin
                    state <= ST_LOAD_B;         // A word arrives now
                end

                ST_LOAD_B: begin
                    state <= ST_EXECUTE;
                end

                ST_EXECUTE, ST_STORE: begin
                    if (pnl_automatic) begin
                        sel   <= strt;
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // memory strobes
    assign mem.addr       = sel;
    assign mem.read       = (state == ST_FETCH) ||
                            (state == ST_READ_A) ||
                            (state == ST_READ_B);
    assign mem.write      = (state == ST_STORE) ||
                            ((state == ST_IDLE) && pnl_do_store);
    assign mem.write_data = alu.reg_c;

    // arithmetic strobes, one cycle each
    assign alu.operand = mem.read_data;
    assign alu.load_a  = (state == ST_READ_B);
    assign alu.load_b  = (state == ST_LOAD_B);
    assign alu.operate = (state == ST_EXECUTE);
    assign alu.op      = ir.order.op;

    assign op_code    = ir.order.op;
    assign strt_value = strt;
    assign sel_value  = sel;

endmodule

`default_nettype wire

/* verification/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;

    logic               clk;
    logic               reset;
    logic               pnl_start_pulse;
    logic               pnl_clear_pu;
    logic               pnl_automatic;
    logic               pnl_do_arr_c;
    logic [WORD_W-1:0]  pnl_arr_reg_c_value;
    logic               pnl_do_arr_strt;
    logic [ADDR_W-1:0]  pnl_arr_strt_value;
    logic               pnl_do_arr_sel;
    logic [ADDR_W-1:0]  pnl_arr_sel_value;
    logic               pnl_do_store;
    logic [OP_W-1:0]    pnl_op_code;
    logic [ADDR_W-1:0]  pnl_strt_value;
    logic [ADDR_W-1:0]  pnl_sel_value;
    logic [WORD_W-1:0]  pnl_reg_c_value;
    logic [STATE_W-1:0] pnl_pu_state;

    int error_count;
    int check_count;
    int cycle_count;

    core_top u_dut (
        .clk                 ( clk                 ),
        .reset               ( reset               ),
        .pnl_start_pulse     ( pnl_start_pulse     ),
        .pnl_clear_pu        ( pnl_clear_pu        ),
        .pnl_automatic       ( pnl_automatic       ),
        .pnl_do_arr_c        ( pnl_do_arr_c        ),
        .pnl_arr_reg_c_value ( pnl_arr_reg_c_value ),
        .pnl_do_arr_strt     ( pnl_do_arr_strt     ),
        .pnl_arr_strt_value  ( pnl_arr_strt_value  ),
        .pnl_do_arr_sel      ( pnl_do_arr_sel      ),
        .pnl_arr_sel_value   ( pnl_arr_sel_value   ),
        .pnl_do_store        ( pnl_do_store        ),
        .pnl_op_code         ( pnl_op_code         ),
        .pnl_strt_value      ( pnl_strt_value      ),
        .pnl_sel_value       ( pnl_sel_value       ),
        .pnl_reg_c_value     ( pnl_reg_c_value     ),
        .pnl_pu_state        ( pnl_pu_state        )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [WORD_W-1:0] order_word(input logic [OP_W-1:0] op,
            input logic [ADDR_W-1:0] addr1, input logic [ADDR_W-1:0] addr2);
        return {1'b0, op, addr1, addr2};
    endfunction

    function automatic logic [WORD_W-1:0] random_number();
        return {1'($urandom), MAG_W'($urandom)};
    endfunction

    // signed sum through integers, magnitude wraps mod 2^30
    function automatic logic [WORD_W-1:0] expected_addsub(input logic [WORD_W-1:0] a,
            input logic [WORD_W-1:0] b, input logic subtract);
        longint           va;
        longint           vb;
        longint           total;
        longint           size;
        logic             b_neg;
        logic             sign;
        logic [MAG_W-1:0] mag;
        size  = longint'(1) << MAG_W;
        b_neg = b[WORD_W-1] ^ subtract;
        va    = a[WORD_W-1] ? -longint'(a[MAG_W-1:0]) : longint'(a[MAG_W-1:0]);
        vb    = b_neg ? -longint'(b[MAG_W-1:0]) : longint'(b[MAG_W-1:0]);
        total = va + vb;
        if (a[WORD_W-1] == b_neg) begin
            sign = a[WORD_W-1];
        end else begin
            sign = (total < 0);     // larger magnitude decides
        end
        if (total < 0) begin
            total = -total;
        end
        mag = MAG_W'(total % size);
        if (mag == '0) begin
            sign = 1'b0;
        end
        return {sign, mag};
    endfunction

    function automatic logic [WORD_W-1:0] expected_and(input logic [WORD_W-1:0] a,
            input logic [WORD_W-1:0] b);
        logic             sign;
        logic [MAG_W-1:0] mag;
        sign = a[WORD_W-1] & b[WORD_W-1];
        mag  = a[MAG_W-1:0] & b[MAG_W-1:0];
        if (mag == '0) begin
            sign = 1'b0;
        end
        return {sign, mag};
    endfunction

    // panel load, select and C first, then the store pulse
    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] value);
        @(negedge clk);
        pnl_do_arr_sel      = 1'b1;
        pnl_arr_sel_value   = addr;
        pnl_do_arr_c        = 1'b1;
        pnl_arr_reg_c_value = value;
        @(negedge clk);
        pnl_do_arr_sel = 1'b0;
        pnl_do_arr_c   = 1'b0;
        pnl_do_store   = 1'b1;
        @(negedge clk);
        pnl_do_store = 1'b0;
    endtask

    task automatic arrange_start(input logic [ADDR_W-1:0] addr);
        @(negedge clk);
        pnl_do_arr_strt    = 1'b1;
        pnl_arr_strt_value = addr;
        @(negedge clk);
        pnl_do_arr_strt = 1'b0;
    endtask

    task automatic start_run(input logic [ADDR_W-1:0] addr, input logic automatic_mode);
        arrange_start(addr);
        @(negedge clk);
        pnl_automatic   = automatic_mode;
        pnl_start_pulse = 1'b1;
        @(negedge clk);
        pnl_start_pulse = 1'b0;
    endtask

    task automatic wait_idle();
        while (pnl_pu_state != ST_IDLE) begin
            @(negedge clk);
        end
    endtask

    task automatic step_once();
        @(negedge clk);
        pnl_start_pulse = 1'b1;
        @(negedge clk);
        pnl_start_pulse = 1'b0;
        wait_idle();
    endtask

    task automatic clear_unit();
        @(negedge clk);
        pnl_clear_pu = 1'b1;
        @(negedge clk);
        pnl_clear_pu = 1'b0;
    endtask

    // one order then stop, operands at data and data + 1
    task automatic load_arith_program(input logic [ADDR_W-1:0] base, input logic [OP_W-1:0] op,
            input logic [ADDR_W-1:0] data, input logic [WORD_W-1:0] a,
            input logic [WORD_W-1:0] b);
        store_word(base, order_word(op, data, data + ADDR_W'(1)));
        store_word(base + ADDR_W'(1), order_word(OP_STOP, '0, '0));
        store_word(data, a);
        store_word(data + ADDR_W'(1), b);
    endtask

    task automatic test_panel_regs();
        logic [ADDR_W-1:0] loop_addr;
        logic [ADDR_W-1:0] strt_val;
        logic [ADDR_W-1:0] sel_val;
        logic [WORD_W-1:0] c_val;
        loop_addr = 12'h0F0;
        store_word(loop_addr, order_word(OP_JUMP, '0, loop_addr));
        strt_val = ADDR_W'($urandom);
        sel_val  = ADDR_W'($urandom);
        c_val    = random_number();
        @(negedge clk);
        pnl_do_arr_strt     = 1'b1;
        pnl_arr_strt_value  = strt_val;
        pnl_do_arr_sel      = 1'b1;
        pnl_arr_sel_value   = sel_val;
        pnl_do_arr_c        = 1'b1;
        pnl_arr_reg_c_value = c_val;
        @(negedge clk);
        pnl_do_arr_strt = 1'b0;
        pnl_do_arr_sel  = 1'b0;
        pnl_do_arr_c    = 1'b0;
        check_value("panel_regs strt", strt_val, pnl_strt_value);
        check_value("panel_regs sel", sel_val, pnl_sel_value);
        check_value("panel_regs C", c_val, pnl_reg_c_value);

        // arranges during a run must not land, pulse falls in a fetch cycle
        start_run(loop_addr, 1'b1);
        repeat (6) @(negedge clk);
        pnl_do_arr_strt    = 1'b1;
        pnl_arr_strt_value = ~loop_addr;
        pnl_do_arr_sel     = 1'b1;
        pnl_arr_sel_value  = ~loop_addr;
        @(negedge clk);
        pnl_do_arr_strt = 1'b0;
        pnl_do_arr_sel  = 1'b0;
        check_value("panel_regs running", 1, pnl_pu_state != ST_IDLE);
        check_value("panel_regs loop strt", loop_addr, pnl_strt_value);
        check_value("panel_regs loop sel", loop_addr, pnl_sel_value);
        clear_unit();
        wait_idle();
    endtask

    task automatic test_add_sub();
        logic [OP_W-1:0]   op;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        for (int i = 0; i < 20; i++) begin
            op = (i % 2 == 1) ? OP_SUB : OP_ADD;
            a  = random_number();
            b  = random_number();
            case (i)
                0: a[MAG_W-1:0] = '0;
                1: b = a;                                   // x - x
                2: begin
                    a[MAG_W-1]  = 1'b1;                     // like signs, wraps
                    b[MAG_W-1]  = 1'b1;
                    b[WORD_W-1] = a[WORD_W-1];
                end
                3: begin
                    a[MAG_W-1]  = 1'b1;
                    b[MAG_W-1]  = 1'b1;
                    b[WORD_W-1] = ~a[WORD_W-1];
                end
                4: begin
                    a = {1'b1, {MAG_W{1'b0}}};              // two negative zeros
                    b = a;
                end
                6: b = {~a[WORD_W-1], a[MAG_W-1:0]};
                default: ;
            endcase
            load_arith_program(12'h020, op, 12'h200, a, b);
            start_run(12'h020, 1'b1);
            wait_idle();
            check_value($sformatf("add_sub[%0d] C", i), expected_addsub(a, b, op == OP_SUB),
                        pnl_reg_c_value);
            check_value($sformatf("add_sub[%0d] strt", i), 12'h022, pnl_strt_value);
        end
    endtask

    task automatic test_and();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        for (int i = 0; i < 10; i++) begin
            a = random_number();
            b = random_number();
            if (i == 0) begin
                a[WORD_W-1]  = 1'b1;                        // disjoint bits, both negative
                b            = {1'b1, ~a[MAG_W-1:0]};
            end
            load_arith_program(12'h030, OP_AND, 12'h300, a, b);
            start_run(12'h030, 1'b1);
            wait_idle();
            check_value($sformatf("and[%0d] C", i), expected_and(a, b), pnl_reg_c_value);
            check_value($sformatf("and[%0d] strt", i), 12'h032, pnl_strt_value);
        end
    endtask

    task automatic test_store_jump();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] sum;
        a   = random_number();
        b   = random_number();
        sum = expected_addsub(a, b, 1'b0);
        store_word(12'h040, order_word(OP_ADD, 12'h400, 12'h401));
        store_word(12'h041, order_word(OP_STORE, '0, 12'h402));
        store_word(12'h042, order_word(OP_JUMP, '0, 12'hA00));
        store_word(12'hA00, order_word(OP_STOP, '0, '0));
        store_word(12'h400, a);
        store_word(12'h401, b);
        start_run(12'h040, 1'b1);
        wait_idle();
        check_value("store_jump C", sum, pnl_reg_c_value);
        check_value("store_jump strt", 12'hA01, pnl_strt_value);

        // read the stored sum back by adding zero
        store_word(12'h050, order_word(OP_ADD, 12'h402, 12'h403));
        store_word(12'h051, order_word(OP_STOP, '0, '0));
        store_word(12'h403, '0);
        start_run(12'h050, 1'b1);
        wait_idle();
        check_value("store_jump readback", sum, pnl_reg_c_value);
        check_value("store_jump readback strt", 12'h052, pnl_strt_value);
    endtask

    task automatic test_single_step();
        logic [OP_W-1:0]   step_op   [6];
        logic [ADDR_W-1:0] step_strt [6];
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        step_op   = '{OP_ADD, OP_STORE, OP_JUMP, OP_SUB, 6'o77, OP_STOP};
        step_strt = '{12'h061, 12'h062, 12'h070, 12'h071, 12'h072, 12'h073};
        a = random_number();
        b = random_number();
        store_word(12'h060, order_word(OP_ADD, 12'h600, 12'h601));
        store_word(12'h061, order_word(OP_STORE, '0, 12'h602));
        store_word(12'h062, order_word(OP_JUMP, '0, 12'h070));
        store_word(12'h070, order_word(OP_SUB, 12'h600, 12'h601));
        store_word(12'h071, order_word(6'o77, 12'h123, 12'h456));  // no-op
        store_word(12'h072, order_word(OP_STOP, '0, '0));
        store_word(12'h600, a);
        store_word(12'h601, b);
        pnl_automatic = 1'b0;
        arrange_start(12'h060);
        for (int i = 0; i < 6; i++) begin
            step_once();
            @(negedge clk);     // must stay stopped
            check_value($sformatf("single_step[%0d] state", i), ST_IDLE, pnl_pu_state);
            check_value($sformatf("single_step[%0d] strt", i), step_strt[i], pnl_strt_value);
            check_value($sformatf("single_step[%0d] op", i), step_op[i], pnl_op_code);
            if (i == 0) begin
                check_value("single_step add C", expected_addsub(a, b, 1'b0), pnl_reg_c_value);
            end else if (i == 3) begin
                check_value("single_step sub C", expected_addsub(a, b, 1'b1), pnl_reg_c_value);
            end
        end
    endtask

    task automatic test_clear();
        store_word(12'h7F0, order_word(OP_JUMP, '0, 12'h7F0));
        start_run(12'h7F0, 1'b1);
        repeat (9) @(negedge clk);
        check_value("clear running", 1, pnl_pu_state != ST_IDLE);
        clear_unit();
        check_value("clear state", ST_IDLE, pnl_pu_state);
        check_value("clear strt", 12'h7F0, pnl_strt_value);
    endtask

    initial begin
        clk                 = 1'b0;
        reset               = 1'b1;
        pnl_start_pulse     = 1'b0;
        pnl_clear_pu        = 1'b0;
        pnl_automatic       = 1'b0;
        pnl_do_arr_c        = 1'b0;
        pnl_arr_reg_c_value = '0;
        pnl_do_arr_strt     = 1'b0;
        pnl_arr_strt_value  = '0;
        pnl_do_arr_sel      = 1'b0;
        pnl_arr_sel_value   = '0;
        pnl_do_store        = 1'b0;
        error_count         = 0;
        check_count         = 0;
        cycle_count         = 0;
        void'($urandom(71));
        repeat (2) @(negedge clk);
        reset = 1'b0;

        test_panel_regs();
        test_add_sub();
        test_and();
        test_store_jump();
        test_single_step();
        test_clear();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
